// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module ext_mem_tb -f vlog.f -o ext_mem_sim \
   && ./obj_dir/ext_mem_sim \
   || { echo "build or simulation returned an error"; exit 1; }

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter int period_ns = 40
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

endmodule

// File: sim/ext_mem_checker.sv
`timescale 1ns/1ps

module ext_mem_checker (
   input logic                   clk,
   input logic                   rst,
   input ext_mem_pkg::mem_req_t  i_req,
   input ext_mem_pkg::mem_resp_t i_resp,
   input ext_mem_pkg::mem_req_t  d_req,
   input ext_mem_pkg::mem_resp_t d_resp,
   input ext_mem_pkg::be_req_t   be_req,
   input ext_mem_pkg::be_resp_t  be_resp
);

   // Native masters hold the whole request until ready
   i_hold: assert property (@(posedge clk) disable iff (rst)
      i_req.valid && !i_resp.ready |=> i_req.valid && $stable(i_req))
      else $error("instruction request dropped or changed before ready");

   d_hold: assert property (@(posedge clk) disable iff (rst)
      d_req.valid && !d_resp.ready |=> d_req.valid && $stable(d_req))
      else $error("data request dropped or changed before ready");

   // Backend request held by the cache until the memory answers
   be_hold: assert property (@(posedge clk) disable iff (rst)
      be_req.valid && !be_resp.ready |=> be_req.valid && $stable(be_req))
      else $error("backend request dropped or changed before ready");

   one_ready: assert property (@(posedge clk) disable iff (rst)
      !(i_resp.ready && d_resp.ready))
      else $error("ready reached both masters in the same cycle");

   be_quiet_in_reset: assert property (@(posedge clk) rst |-> !be_req.valid)
      else $error("backend valid high during reset");

endmodule

// File: sim/ext_mem_tb.sv
`timescale 1ns/1ps

module ext_mem_tb;

   localparam logic [3:0] op_i_read     = 4'h1;
   localparam logic [3:0] op_d_read     = 4'h2;
   localparam logic [3:0] op_d_write    = 4'h3;
   localparam logic [3:0] op_pair       = 4'h4;
   localparam logic [3:0] op_invalidate = 4'h5;
   localparam int         mem_words     = 65536;

   // One line of the tests file
   typedef struct packed {
      logic [3:0]          op;
      ext_mem_pkg::addr_t  iaddr;
      ext_mem_pkg::data_t  idata;
      ext_mem_pkg::addr_t  daddr;
      ext_mem_pkg::data_t  ddata;
      ext_mem_pkg::strb_t  strb;
      logic                inv;
      logic [7:0]          reads;
   } test_line_t;

   logic                   clk;
   logic                   rst;
   logic                   invalidate;
   ext_mem_pkg::mem_req_t  i_req;
   ext_mem_pkg::mem_resp_t i_resp;
   ext_mem_pkg::mem_req_t  d_req;
   ext_mem_pkg::mem_resp_t d_resp;
   ext_mem_pkg::be_req_t   be_req;
   ext_mem_pkg::be_resp_t  be_resp;

   ext_mem_pkg::data_t backing [mem_words];
   test_line_t         tests[$];
   int                 be_reads;
   logic               tests_loaded;

   clk_gen #(.period_ns(40)) i_clk_gen (.clk(clk));

   ext_mem #(
      .line_index_w (6),
      .tag_w        (10)
   ) i_ext_mem (
      .clk        (clk),
      .rst        (rst),
      .i_req      (i_req),
      .i_resp     (i_resp),
      .d_req      (d_req),
      .d_resp     (d_resp),
      .invalidate (invalidate),
      .be_req     (be_req),
      .be_resp    (be_resp)
   );

   bind ext_mem ext_mem_checker i_ext_mem_checker (
      .clk     (clk),
      .rst     (rst),
      .i_req   (i_req),
      .i_resp  (i_resp),
      .d_req   (d_req),
      .d_resp  (d_resp),
      .be_req  (be_req),
      .be_resp (be_resp)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("sim failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_resp(input ext_mem_pkg::data_t got, input ext_mem_pkg::data_t exp,
                             input string what);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %0d ns: %s returned %h, expected %h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         abort_run($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d",
                             $time, what, got, exp));
      end
   endtask

   task automatic load_tests();
      int         fd;
      int         n;
      string      line;
      test_line_t t;
      logic [3:0] op;
      logic [15:0] iaddr;
      logic [15:0] daddr;
      logic [31:0] idata;
      logic [31:0] ddata;
      logic [3:0] strb;
      logic       inv;
      logic [7:0] reads;
      fd = $fopen("sim/ext_mem_tests.txt", "r");
      if (fd == 0) begin
         abort_run("Could not open the tests file sim/ext_mem_tests.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           op, iaddr, idata, daddr, ddata, strb, inv, reads);
               if (n != 8) begin
                  abort_run({"Malformed line in the tests file: ", line});
               end
               t = '{op: op, iaddr: iaddr, idata: idata, daddr: daddr, ddata: ddata,
                     strb: strb, inv: inv, reads: reads};
               tests.push_back(t);
            end
         end
         $fclose(fd);
      end
   endtask

   // Issue one operation and wait for every ready it needs
   task automatic run_line(input test_line_t t);
      logic use_i;
      logic use_d;
      logic i_done;
      logic d_done;
      int   cycle;
      use_i = (t.op == op_i_read) || (t.op == op_pair);
      use_d = (t.op == op_d_read) || (t.op == op_d_write) || (t.op == op_pair);
      @(posedge clk);
      if (t.op == op_invalidate) begin
         invalidate <= 1'b1;
         @(posedge clk);
         invalidate <= 1'b0;
      end else begin
         if (use_i) begin
            i_req <= '{valid: 1'b1, addr: t.iaddr, wdata: '0, wstrb: '0};
         end
         if (use_d) begin
            d_req <= '{valid: 1'b1, addr: t.daddr,
                       wdata: (t.op == op_d_write) ? t.ddata : '0,
                       wstrb: (t.op == op_d_write) ? t.strb : '0};
         end
         i_done = !use_i;
         d_done = !use_d;
         cycle  = 0;
         while (!(i_done && d_done)) begin
            @(posedge clk);
            cycle++;
            // Pulse invalidate while the request is still being served
            if (t.inv) begin
               invalidate <= (cycle == 1);
            end
            if (i_done && i_resp.ready) begin
               abort_run("Instruction bus saw ready with no request of its own pending");
            end
            if (d_done && d_resp.ready) begin
               abort_run("Data bus saw ready with no request of its own pending");
            end
            if (!i_done && i_resp.ready) begin
               check_resp(i_resp.rdata, t.idata, "instruction read");
               i_req.valid <= 1'b0;
               i_done = 1'b1;
            end
            if (!d_done && d_resp.ready) begin
               if (t.op != op_d_write) begin
                  check_resp(d_resp.rdata, t.ddata, "data read");
               end
               d_req.valid <= 1'b0;
               d_done = 1'b1;
            end
         end
         invalidate <= 1'b0;
      end
      if (t.reads != 8'hff) begin
         check_count(be_reads, int'(t.reads), "backend read count");
      end
   endtask

   // Backend memory with a random answer delay
   initial begin : backend_model
      int                 wait_cycles;
      ext_mem_pkg::data_t word;
      wait_cycles = -1;
      be_reads    = 0;
      void'($urandom(32'h4d81d4f5));
      be_resp <= '0;
      for (int a = 0; a < mem_words; a++) begin
         backing[a] = ext_mem_pkg::data_t'(a) ^ 32'h5a5a0000;
      end
      forever begin
         @(posedge clk);
         if (be_resp.ready) begin
            be_resp.ready <= 1'b0;
         end else if (!rst && be_req.valid) begin
            if (wait_cycles < 0) begin
               wait_cycles = int'($urandom_range(3, 0));
            end
            if (wait_cycles == 0) begin
               word = backing[be_req.addr];
               if (be_req.we == '0) begin
                  be_reads++;
                  be_resp.rdata <= word;
               end else begin
                  for (int b = 0; b < 4; b++) begin
                     if (be_req.we[b]) begin
                        word[8*b +: 8] = be_req.wdata[8*b +: 8];
                     end
                  end
                  backing[be_req.addr] = word;
               end
               be_resp.ready <= 1'b1;
               wait_cycles = -1;
            end else begin
               wait_cycles--;
            end
         end
      end
   end

   initial begin : watchdog
      wait (tests_loaded);
      repeat (tests.size() * 200) @(posedge clk);
      abort_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
                          tests.size() * 200));
   end

   initial begin : main
      tests_loaded = 1'b0;
      rst          <= 1'b1;
      invalidate   <= 1'b0;
      i_req        <= '0;
      d_req        <= '0;
      load_tests();
      tests_loaded = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int n = 0; n < tests.size(); n++) begin
         run_line(tests[n]);
      end
      repeat (2) @(posedge clk);
      $display("sim passed");
      $finish;
   end

endmodule

// File: sim/ext_mem_tests.txt
# op: 1 i-read, 2 d-read, 3 d-write, 4 pair, 5 invalidate; every field is hex
# op iaddr idata daddr ddata strb inv reads (reads = backend reads so far, ff = not checked)
2 0000 00000000 0008 5a5a0008 0 0 01
2 0000 00000000 0008 5a5a0008 0 0 01
1 0123 5a5a0123 0000 00000000 0 0 02
1 0123 5a5a0123 0000 00000000 0 0 02
3 0000 00000000 0008 a1b2c3d4 3 0 02
2 0000 00000000 0008 5a5ac3d4 0 0 02
3 0000 00000000 0200 11223344 c 0 02
2 0000 00000000 0200 11220200 0 0 03
2 0000 00000000 0050 5a5a0050 0 0 04
2 0000 00000000 0450 5a5a0450 0 0 05
2 0000 00000000 0050 5a5a0050 0 0 06
1 0450 5a5a0450 0000 00000000 0 0 07
3 0000 00000000 0450 deadbeef f 0 07
2 0000 00000000 0050 5a5a0050 0 0 08
2 0000 00000000 0450 deadbeef 0 0 09
4 0123 5a5a0123 0300 5a5a0300 0 0 0a
4 0777 5a5a0777 0008 5a5ac3d4 0 0 0b
5 0000 00000000 0000 00000000 0 0 ff
2 0000 00000000 0008 5a5ac3d4 0 0 0c
1 0123 5a5a0123 0000 00000000 0 0 0d
2 0000 00000000 0008 5a5ac3d4 0 1 0d
2 0000 00000000 0008 5a5ac3d4 0 0 0e
3 0000 00000000 0009 00000099 1 0 0e
2 0000 00000000 0009 5a5a0099 0 0 0f
4 0009 5a5a0099 0008 5a5ac3d4 0 0 0f

// File: verilog/bus_merge.sv
`timescale 1ns/1ps

module bus_merge (
   input  logic                   clk,
   input  logic                   rst,
   input  ext_mem_pkg::mem_req_t  i_req,
   output ext_mem_pkg::mem_resp_t i_resp,
   input  ext_mem_pkg::mem_req_t  d_req,
   output ext_mem_pkg::mem_resp_t d_resp,
   output ext_mem_pkg::mem_req_t  s_req,
   input  ext_mem_pkg::mem_resp_t s_resp
);

   ext_mem_pkg::merge_state_e state;

   // Granted source while busy, 1 selects the data bus
   logic grant_d;

   // Data bus wins a tie when set
   logic prio_d;

   // Current selection, combinational so the grant costs no cycle
   logic sel_d;

   logic done;

   always_comb begin
      if (state == ext_mem_pkg::merge_busy) begin
         sel_d = grant_d;
      end else begin
         sel_d = d_req.valid && (prio_d || !i_req.valid);
      end
   end

   // Granted request goes to the cache unchanged
   assign s_req = sel_d ? d_req : i_req;

   assign done = s_req.valid && s_resp.ready;

   // Ready and read data reach only the granted master
   always_comb begin
      d_resp.ready = s_resp.ready && s_req.valid && sel_d;
      i_resp.ready = s_resp.ready && s_req.valid && !sel_d;
      d_resp.rdata = sel_d ? s_resp.rdata : '0;
      i_resp.rdata = sel_d ? '0 : s_resp.rdata;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= ext_mem_pkg::merge_idle;
         grant_d <= 1'b0;
         prio_d  <= 1'b1;
      end else begin
         if (s_req.valid) begin
            grant_d <= sel_d;
            if (done) begin
               // Transfer finished, the other bus gets the next tie
               state  <= ext_mem_pkg::merge_idle;
               prio_d <= !sel_d;
            end else begin
               state <= ext_mem_pkg::merge_busy;
            end
         end
      end
   end

endmodule

// File: verilog/ext_mem.sv
`timescale 1ns/1ps

module ext_mem #(
   parameter int line_index_w = 6,
   parameter int tag_w        = 10
) (
   input  logic                   clk,
   input  logic                   rst,

   // Instruction bus, reads only
   input  ext_mem_pkg::mem_req_t  i_req,
   output ext_mem_pkg::mem_resp_t i_resp,

   // Data bus
   input  ext_mem_pkg::mem_req_t  d_req,
   output ext_mem_pkg::mem_resp_t d_resp,

   // One-cycle pulse, served once the cache is between requests
   input  logic                   invalidate,

   // Backend memory port
   output ext_mem_pkg::be_req_t   be_req,
   input  ext_mem_pkg::be_resp_t  be_resp
);

   // Merged stream between arbiter and cache
   ext_mem_pkg::mem_req_t  l2_req;
   ext_mem_pkg::mem_resp_t l2_resp;

   bus_merge i_bus_merge (
      .clk    (clk),
      .rst    (rst),
      .i_req  (i_req),
      .i_resp (i_resp),
      .d_req  (d_req),
      .d_resp (d_resp),
      .s_req  (l2_req),
      .s_resp (l2_resp)
   );

   l2_cache #(
      .line_index_w (line_index_w),
      .tag_w        (tag_w)
   ) i_l2_cache (
      .clk        (clk),
      .rst        (rst),
      .req        (l2_req),
      .resp       (l2_resp),
      .invalidate (invalidate),
      .be_req     (be_req),
      .be_resp    (be_resp)
   );

endmodule

// File: verilog/ext_mem_pkg.sv
package ext_mem_pkg;

   // Word address, split into tag and line index by the cache
   typedef logic [15:0] addr_t;

   // One data word
   typedef logic [31:0] data_t;

   // Byte write strobes, all zero for a read
   typedef logic [3:0] strb_t;

   // Cache line index and stored tag
   typedef logic [5:0] index_t;
   typedef logic [9:0] tag_t;

   // Native bus request, held by the master until ready
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } mem_req_t;

   // Native bus response, rdata valid with ready
   typedef struct packed {
      logic  ready;
      data_t rdata;
   } mem_resp_t;

   // Backend request
   // we carries the byte enables of a write, zero means read
   typedef struct packed {
      logic  valid;
      strb_t we;
      addr_t addr;
      data_t wdata;
   } be_req_t;

   typedef struct packed {
      logic  ready;
      data_t rdata;
   } be_resp_t;

   typedef enum logic {
      merge_idle,
      merge_busy
   } merge_state_e;

   typedef enum logic [2:0] {
      cache_idle,
      cache_lookup,
      cache_fill,
      cache_write_through,
      cache_respond,
      cache_invalidate
   } cache_state_e;

endpackage

// File: verilog/l2_cache.sv
`timescale 1ns/1ps

module l2_cache #(
   parameter int line_index_w = 6,
   parameter int tag_w        = 10
) (
   input  logic                   clk,
   input  logic                   rst,
   input  ext_mem_pkg::mem_req_t  req,
   output ext_mem_pkg::mem_resp_t resp,
   input  logic                   invalidate,
   output ext_mem_pkg::be_req_t   be_req,
   input  ext_mem_pkg::be_resp_t  be_resp
);

   localparam int lines = 2 ** line_index_w;
   localparam int n_bytes = $bits(ext_mem_pkg::strb_t);

   ext_mem_pkg::cache_state_e state;

   // Line storage, only the valid bits are cleared by reset
   logic [lines-1:0]   valid_q;
   ext_mem_pkg::tag_t  tag_mem [lines];
   ext_mem_pkg::data_t data_mem [lines];

   ext_mem_pkg::index_t idx;
   ext_mem_pkg::tag_t   tag;
   ext_mem_pkg::index_t sweep_idx;
   ext_mem_pkg::data_t  rdata_q;
   ext_mem_pkg::data_t  merged;

   logic inv_pend;
   logic is_write;
   logic hit;
   logic sweep_last;
   logic start_sweep;

   // The master holds the request, so it is decoded straight from the bus
   assign idx = ext_mem_pkg::index_t'(req.addr[line_index_w-1:0]);
   assign tag = ext_mem_pkg::tag_t'(req.addr[line_index_w +: tag_w]);

   assign is_write = |req.wstrb;
   assign hit = valid_q[idx] && (tag_mem[idx] == tag);

   assign sweep_last = (sweep_idx == ext_mem_pkg::index_t'(lines - 1));

   // Invalidate only between requests
   assign start_sweep = (state == ext_mem_pkg::cache_idle) && !req.valid && inv_pend;

   // Stored word with the written bytes replaced
   always_comb begin
      merged = data_mem[idx];
      for (int b = 0; b < n_bytes; b++) begin
         if (req.wstrb[b]) begin
            merged[8*b +: 8] = req.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         inv_pend <= 1'b0;
      end else if (invalidate) begin
         inv_pend <= 1'b1;
      end else if (start_sweep) begin
         inv_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= ext_mem_pkg::cache_idle;
         valid_q   <= '0;
         sweep_idx <= '0;
      end else begin
         case (state)
            ext_mem_pkg::cache_idle: begin
               if (req.valid) begin
                  state <= ext_mem_pkg::cache_lookup;
               end else if (inv_pend) begin
                  state     <= ext_mem_pkg::cache_invalidate;
                  sweep_idx <= '0;
               end
            end

            ext_mem_pkg::cache_lookup: begin
               if (is_write) begin
                  // Write-through on hit and miss, no allocate
                  state <= ext_mem_pkg::cache_write_through;
               end else if (hit) begin
                  state <= ext_mem_pkg::cache_respond;
               end else begin
                  state <= ext_mem_pkg::cache_fill;
               end
            end

            ext_mem_pkg::cache_fill: begin
               if (be_resp.ready) begin
                  valid_q[idx] <= 1'b1;
                  state        <= ext_mem_pkg::cache_respond;
               end
            end

            ext_mem_pkg::cache_write_through: begin
               if (be_resp.ready) begin
                  state <= ext_mem_pkg::cache_respond;
               end
            end

            ext_mem_pkg::cache_respond: begin
               state <= ext_mem_pkg::cache_idle;
            end

            ext_mem_pkg::cache_invalidate: begin
               // One line per cycle
               valid_q[sweep_idx] <= 1'b0;
               sweep_idx          <= sweep_idx + 1'b1;
               if (sweep_last) begin
                  state <= ext_mem_pkg::cache_idle;
               end
            end

            default: begin
               state <= ext_mem_pkg::cache_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ext_mem_pkg::cache_lookup) begin
         if (is_write) begin
            if (hit) begin
               data_mem[idx] <= merged;
            end
         end else begin
            rdata_q <= data_mem[idx];
         end
      end
      if (state == ext_mem_pkg::cache_fill && be_resp.ready) begin
         data_mem[idx] <= be_resp.rdata;
         tag_mem[idx]  <= tag;
         rdata_q       <= be_resp.rdata;
      end
   end

   assign resp.ready = (state == ext_mem_pkg::cache_respond);
   assign resp.rdata = rdata_q;

   // Backend request held for the whole fill or write-through state
   always_comb begin
      be_req.valid = (state == ext_mem_pkg::cache_fill) ||
                     (state == ext_mem_pkg::cache_write_through);
      be_req.we    = (state == ext_mem_pkg::cache_write_through) ? req.wstrb : '0;
      be_req.addr  = req.addr;
      be_req.wdata = req.wdata;
   end

endmodule

// File: vlog.f
verilog/ext_mem_pkg.sv
verilog/bus_merge.sv
verilog/l2_cache.sv
verilog/ext_mem.sv
sim/clk_gen.sv
sim/ext_mem_checker.sv
sim/ext_mem_tb.sv
